//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = sdiTb
FILELIST  = sdi.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- rtl/sampleCapture.sv
`timescale 1ns/1ns

module sampleCapture (
    input  logic            clk,
    input  logic            fifoFull,
    input  sdiPkg::sdiCtrlT ctrl,
    input  logic            iSymEn,
    input  sdiPkg::rawT     iSymData,
    input  sdiPkg::rawT     qSymData,
    input  logic            eyeSync,
    input  sdiPkg::rawT     iEye,
    input  sdiPkg::rawT     qEye,
    input  logic            bufFull,
    output logic            capArmed,
    output logic            bufWrite,
    output sdiPkg::iqPairT  bufData
);

    logic             armMeta;
    logic             isConst;
    logic             symWrite;
    logic             eyeWrite;
    sdiPkg::eyeStateE eyeState;

    // enable crosses from the register side through two flops
    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            armMeta  <= 1'b0;
            capArmed <= 1'b0;
        end else begin
            armMeta  <= ctrl.enable;
            capArmed <= armMeta;
        end
    end

    // eye capture waits for a symbol aligned sync before taking samples
    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            eyeState <= sdiPkg::EYE_IDLE;
        end else if (eyeSync) begin
            case (eyeState)
                sdiPkg::EYE_IDLE: begin
                    if (capArmed && iSymEn) begin
                        eyeState <= sdiPkg::EYE_WAIT;
                    end
                end
                sdiPkg::EYE_WAIT: begin
                    if (!capArmed) begin
                        eyeState <= sdiPkg::EYE_IDLE;
                    end
                end
                default: eyeState <= sdiPkg::EYE_IDLE;
            endcase
        end
    end

    assign isConst  = ctrl.mode == sdiPkg::MODE_CONSTELLATION;
    assign symWrite = capArmed && iSymEn;
    assign eyeWrite = capArmed && eyeSync && (eyeState == sdiPkg::EYE_WAIT);
    assign bufWrite = (isConst ? symWrite : eyeWrite) && !bufFull;

    // keep the upper 16 of 18 bits
    assign bufData.i = isConst ? iSymData[17:2] : iEye[17:2];
    assign bufData.q = isConst ? qSymData[17:2] : qEye[17:2];

    noWriteWhenFull: assert property (
        @(posedge clk) disable iff (fifoFull)
        bufFull |-> !bufWrite
    ) else $error("buffer write while full");

    // register auto-disarm plus synchronizer delay
    fullDisarms: assert property (
        @(posedge clk) disable iff (fifoFull)
        $rose(bufFull) |-> ##[1:3] !capArmed
    ) else $error("capture still armed after buffer filled");

endmodule

//--- rtl/sdi.sv
`timescale 1ns/1ns

module sdi (
    input  logic           clk,
    input  logic           fifoFull,
    input  sdiPkg::busReqT busReq,
    output sdiPkg::wordT   dataOut,
    input  logic           iSymEn,
    input  sdiPkg::rawT    iSymData,
    input  sdiPkg::rawT    qSymData,
    input  logic           eyeSync,
    input  sdiPkg::rawT    iEye,
    input  sdiPkg::rawT    qEye,
    output logic           sdiOut
);

    sdiPkg::sdiCtrlT ctrl;
    sdiPkg::iqPairT  bufData;
    sdiPkg::iqPairT  bufHead;
    sdiPkg::byteT    byteData;
    logic            capArmed;
    logic            bufWrite;
    logic            bufRead;
    logic            bufClear;
    logic            bufFull;
    logic            bufEmpty;
    logic            byteStrobe;
    logic            txReady;

    sdiRegs regs (
        .clk, .fifoFull, .busReq, .bufFull, .bufEmpty, .ctrl, .dataOut
    );

    sampleCapture capture (
        .clk, .fifoFull, .ctrl,
        .iSymEn, .iSymData, .qSymData,
        .eyeSync, .iEye, .qEye,
        .bufFull, .capArmed, .bufWrite, .bufData
    );

    symbolBuffer buffer (
        .clk, .fifoFull, .bufClear, .bufWrite, .bufData,
        .bufRead, .bufHead, .bufFull, .bufEmpty
    );

    uartFramer framer (
        .clk, .fifoFull, .capArmed, .bufEmpty, .bufHead, .txReady,
        .bufRead, .bufClear, .byteStrobe, .byteData
    );

    // sdiOut is always the uart line
    uartTx tx (
        .clk, .fifoFull, .ctrl, .byteStrobe, .byteData, .txReady, .sdiOut
    );

endmodule

//--- rtl/sdiPkg.sv
package sdiPkg;

    typedef logic [15:0] sampleT;   // captured I or Q value
    typedef logic [17:0] rawT;      // demodulator input
    typedef logic [31:0] wordT;
    typedef logic [7:0]  byteT;
    typedef logic [15:0] baudDivT;  // clocks per UART bit
    typedef logic [3:0]  regAddrT;

    localparam regAddrT ADDR_CONTROL = 4'd0;
    localparam regAddrT ADDR_BAUD    = 4'd4;

    localparam int BUF_DEPTH   = 16;
    localparam int BUF_AW      = 4;
    localparam int FRAME_BYTES = 6;

    // values 2..7 capture like eye mode
    typedef enum logic [2:0] {
        MODE_EYE           = 3'd0,
        MODE_CONSTELLATION = 3'd1
    } sdiModeE;

    typedef enum logic {
        EYE_IDLE,
        EYE_WAIT
    } eyeStateE;

    typedef enum logic [2:0] {
        FR_IDLE,
        FR_CNT_HI,
        FR_CNT_LO,
        FR_I_HI,
        FR_I_LO,
        FR_Q_HI,
        FR_Q_LO
    } frameStateE;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } txStateE;

    typedef struct packed {
        logic    write;     // single cycle strobe
        regAddrT addr;
        wordT    data;
    } busReqT;

    typedef struct packed {
        sampleT i;
        sampleT q;
    } iqPairT;

    typedef struct packed {
        logic    enable;
        sdiModeE mode;
        baudDivT baudDiv;
    } sdiCtrlT;

endpackage

//--- rtl/sdiRegs.sv
`timescale 1ns/1ns

module sdiRegs (
    input  logic            clk,
    input  logic            fifoFull,
    input  sdiPkg::busReqT  busReq,
    input  logic            bufFull,
    input  logic            bufEmpty,
    output sdiPkg::sdiCtrlT ctrl,
    output sdiPkg::wordT    dataOut
);

    logic ctrlWrite;
    logic baudWrite;

    assign ctrlWrite = busReq.write && (busReq.addr == sdiPkg::ADDR_CONTROL);
    assign baudWrite = busReq.write && (busReq.addr == sdiPkg::ADDR_BAUD);

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            ctrl.enable  <= 1'b0;
            ctrl.mode    <= sdiPkg::MODE_EYE;
            ctrl.baudDiv <= '0;     // zero divisor runs at the slowest rate
        end else begin
            if (ctrlWrite) begin
                ctrl.enable <= busReq.data[7];
                ctrl.mode   <= sdiPkg::sdiModeE'(busReq.data[2:0]);
            end
            if (baudWrite) begin
                ctrl.baudDiv <= busReq.data[15:0];
            end
            // buffer full disarms, even against a write in the same cycle
            if (bufFull) begin
                ctrl.enable <= 1'b0;
            end
        end
    end

    always_comb begin
        case (busReq.addr)
            sdiPkg::ADDR_CONTROL: begin
                dataOut = {bufEmpty, 23'd0, ctrl.enable, 4'd0, ctrl.mode};
            end
            sdiPkg::ADDR_BAUD: begin
                dataOut = {16'd0, ctrl.baudDiv};
            end
            default: begin
                dataOut = '0;
            end
        endcase
    end

    // capture source must not switch behind the host's back
    modeOnlyByWrite: assert property (
        @(posedge clk) disable iff (fifoFull)
        $changed(ctrl.mode) |-> $past(ctrlWrite)
    ) else $error("mode changed without a control write");

endmodule

//--- rtl/symbolBuffer.sv
`timescale 1ns/1ns

module symbolBuffer (
    input  logic           clk,
    input  logic           fifoFull,
    input  logic           bufClear,
    input  logic           bufWrite,
    input  sdiPkg::iqPairT bufData,
    input  logic           bufRead,
    output sdiPkg::iqPairT bufHead,
    output logic           bufFull,
    output logic           bufEmpty
);

    localparam int CW = sdiPkg::BUF_AW + 1;

    sdiPkg::iqPairT            mem [sdiPkg::BUF_DEPTH];
    logic [sdiPkg::BUF_AW-1:0] wrPtr;
    logic [sdiPkg::BUF_AW-1:0] rdPtr;
    logic [CW-1:0]             count;

    always_ff @(posedge clk) begin
        if (bufWrite) begin
            mem[wrPtr] <= bufData;
        end
    end

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (bufClear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (bufWrite) wrPtr <= wrPtr + 1'b1;   // pointers wrap at depth
            if (bufRead) rdPtr <= rdPtr + 1'b1;
            if (bufWrite && !bufRead) begin
                count <= count + 1'b1;
            end else if (bufRead && !bufWrite) begin
                count <= count - 1'b1;
            end
        end
    end

    assign bufHead  = mem[rdPtr];   // show-ahead
    assign bufFull  = count == CW'(sdiPkg::BUF_DEPTH);
    assign bufEmpty = count == '0;

    noReadWhenEmpty: assert property (
        @(posedge clk) disable iff (fifoFull)
        bufRead |-> !bufEmpty
    ) else $error("buffer read while empty");

endmodule

//--- rtl/uartFramer.sv
`timescale 1ns/1ns

module uartFramer (
    input  logic           clk,
    input  logic           fifoFull,
    input  logic           capArmed,
    input  logic           bufEmpty,
    input  sdiPkg::iqPairT bufHead,
    input  logic           txReady,
    output logic           bufRead,
    output logic           bufClear,
    output logic           byteStrobe,
    output sdiPkg::byteT   byteData
);

    sdiPkg::frameStateE state;
    logic [15:0]        frameCount;
    logic               drained;

    // back at the count slot with nothing left means the drain is done
    assign drained    = (state == sdiPkg::FR_CNT_HI) && bufEmpty;
    assign byteStrobe = txReady && (state != sdiPkg::FR_IDLE) && !drained;
    assign bufRead    = byteStrobe && (state == sdiPkg::FR_Q_LO);

    always_comb begin
        case (state)
            sdiPkg::FR_CNT_HI: byteData = frameCount[15:8];
            sdiPkg::FR_CNT_LO: byteData = frameCount[7:0];
            sdiPkg::FR_I_HI:   byteData = bufHead.i[15:8];
            sdiPkg::FR_I_LO:   byteData = bufHead.i[7:0];
            sdiPkg::FR_Q_HI:   byteData = bufHead.q[15:8];
            sdiPkg::FR_Q_LO:   byteData = bufHead.q[7:0];
            default:           byteData = '0;
        endcase
    end

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            state      <= sdiPkg::FR_IDLE;
            frameCount <= '0;
            bufClear   <= 1'b1;
        end else begin
            bufClear <= 1'b0;
            case (state)
                sdiPkg::FR_IDLE: begin
                    // drain only once capture has stopped
                    if (!capArmed && !bufEmpty && txReady) begin
                        state <= sdiPkg::FR_CNT_HI;
                    end
                end
                sdiPkg::FR_CNT_HI: begin
                    if (drained) begin
                        state      <= sdiPkg::FR_IDLE;
                        bufClear   <= 1'b1;
                        frameCount <= '0;
                    end else if (byteStrobe) begin
                        state <= sdiPkg::FR_CNT_LO;
                    end
                end
                sdiPkg::FR_CNT_LO: if (byteStrobe) state <= sdiPkg::FR_I_HI;
                sdiPkg::FR_I_HI:   if (byteStrobe) state <= sdiPkg::FR_I_LO;
                sdiPkg::FR_I_LO:   if (byteStrobe) state <= sdiPkg::FR_Q_HI;
                sdiPkg::FR_Q_HI:   if (byteStrobe) state <= sdiPkg::FR_Q_LO;
                sdiPkg::FR_Q_LO: begin
                    if (byteStrobe) begin
                        state      <= sdiPkg::FR_CNT_HI;
                        frameCount <= frameCount + 1'b1;
                    end
                end
                default: state <= sdiPkg::FR_IDLE;
            endcase
        end
    end

    strobeOnReady: assert property (
        @(posedge clk) disable iff (fifoFull)
        byteStrobe |-> txReady ##1 !txReady
    ) else $error("byte strobe without transmitter handshake");

endmodule

//--- rtl/uartTx.sv
`timescale 1ns/1ns

module uartTx (
    input  logic            clk,
    input  logic            fifoFull,
    input  sdiPkg::sdiCtrlT ctrl,
    input  logic            byteStrobe,
    input  sdiPkg::byteT    byteData,
    output logic            txReady,
    output logic            sdiOut
);

    sdiPkg::txStateE state;
    sdiPkg::baudDivT baudCnt;
    sdiPkg::byteT    shiftReg;
    logic [2:0]      bitCnt;
    logic            baudTick;

    assign baudTick = (state != sdiPkg::TX_IDLE) && (baudCnt == '0);

    always_ff @(posedge clk or posedge fifoFull) begin
        if (fifoFull) begin
            state   <= sdiPkg::TX_IDLE;
            baudCnt <= '0;
            bitCnt  <= '0;
            txReady <= 1'b1;
            sdiOut  <= 1'b1;    // line idles high
        end else begin
            // counter sits at reload until a byte starts
            if (state == sdiPkg::TX_IDLE || baudTick) begin
                baudCnt <= ctrl.baudDiv - 1'b1;
            end else begin
                baudCnt <= baudCnt - 1'b1;
            end
            case (state)
                sdiPkg::TX_IDLE: begin
                    if (byteStrobe) begin
                        state   <= sdiPkg::TX_START;
                        txReady <= 1'b0;
                        sdiOut  <= 1'b0;
                    end
                end
                sdiPkg::TX_START: begin
                    if (baudTick) begin
                        state  <= sdiPkg::TX_DATA;
                        sdiOut <= shiftReg[0];
                        bitCnt <= '0;
                    end
                end
                sdiPkg::TX_DATA: begin
                    if (baudTick) begin
                        if (bitCnt == 3'd7) begin
                            state  <= sdiPkg::TX_STOP;
                            sdiOut <= 1'b1;
                        end else begin
                            sdiOut <= shiftReg[0];
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                end
                sdiPkg::TX_STOP: begin
                    if (baudTick) begin
                        state   <= sdiPkg::TX_IDLE;
                        txReady <= 1'b1;
                    end
                end
                default: state <= sdiPkg::TX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == sdiPkg::TX_IDLE && byteStrobe) begin
            shiftReg <= byteData;
        end else if (baudTick) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

//--- sdi.f
rtl/sdiPkg.sv
rtl/sdiRegs.sv
rtl/sampleCapture.sv
rtl/symbolBuffer.sv
rtl/uartFramer.sv
rtl/uartTx.sv
rtl/sdi.sv
tb/tbClock.sv
tb/sdiTb.sv

//--- tb/sdiTb.sv
`timescale 1ns/1ns

module sdiTb;

    localparam int TB_BAUD      = 4;
    localparam int ARM_WAIT     = 4;
    localparam int TOTAL_FRAMES = 5 + 4 + 16 + 3;
    // frames x bytes x bits x baud, plus slack for register traffic
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * sdiPkg::FRAME_BYTES * 10 * TB_BAUD + 2000;

    logic           clk;
    logic           fifoFull;
    sdiPkg::busReqT busReq;
    sdiPkg::wordT   dataOut;
    logic           iSymEn;
    sdiPkg::rawT    iSymData;
    sdiPkg::rawT    qSymData;
    logic           eyeSync;
    sdiPkg::rawT    iEye;
    sdiPkg::rawT    qEye;
    logic           sdiOut;

    logic [31:0]    lcgState = 32'h8bf3;
    int             cycleCount = 0;
    sdiPkg::sampleT expI[$];
    sdiPkg::sampleT expQ[$];

    tbClock clockGen (.clk);

    sdi dut (
        .clk, .fifoFull, .busReq, .dataOut,
        .iSymEn, .iSymData, .qSymData,
        .eyeSync, .iEye, .qEye, .sdiOut
    );

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic writeReg(input sdiPkg::regAddrT addr, input sdiPkg::wordT data);
        @(posedge clk);
        busReq.write <= 1'b1;
        busReq.addr  <= addr;
        busReq.data  <= data;
        @(posedge clk);
        busReq.write <= 1'b0;
    endtask

    task automatic readReg(input sdiPkg::regAddrT addr, output sdiPkg::wordT data);
        @(posedge clk);
        busReq.write <= 1'b0;
        busReq.addr  <= addr;
        @(negedge clk);
        data = dataOut;     // readback is combinational
    endtask

    task automatic driveSymbols(input int n, input int gap);
        sdiPkg::rawT rawI;
        sdiPkg::rawT rawQ;
        for (int k = 0; k < n; k++) begin
            lcgState = lcgStep(lcgState);
            rawI = lcgState[31:14];
            lcgState = lcgStep(lcgState);
            rawQ = lcgState[31:14];
            @(posedge clk);
            iSymEn   <= 1'b1;
            iSymData <= rawI;
            qSymData <= rawQ;
            expI.push_back(rawI[17:2]);     // upper 16 of 18 bits
            expQ.push_back(rawQ[17:2]);
            repeat (gap) begin
                @(posedge clk);
                iSymEn <= 1'b0;
            end
        end
        @(posedge clk);
        iSymEn <= 1'b0;
    endtask

    task automatic driveEyeSync(input logic withSym, input logic expectWrite);
        sdiPkg::rawT rawI;
        sdiPkg::rawT rawQ;
        lcgState = lcgStep(lcgState);
        rawI = lcgState[31:14];
        lcgState = lcgStep(lcgState);
        rawQ = lcgState[31:14];
        @(posedge clk);
        eyeSync <= 1'b1;
        iSymEn  <= withSym;
        iEye    <= rawI;
        qEye    <= rawQ;
        if (expectWrite) begin
            expI.push_back(rawI[17:2]);
            expQ.push_back(rawQ[17:2]);
        end
        @(posedge clk);
        eyeSync <= 1'b0;
        iSymEn  <= 1'b0;
    endtask

    // samples each bit in its middle, lsb first
    task automatic receiveByte(input string name, output sdiPkg::byteT data);
        do begin
            @(negedge clk);
        end while (sdiOut !== 1'b0);
        repeat (TB_BAUD / 2) @(negedge clk);
        checkValue({name, " start bit"}, 32'd0, 32'(sdiOut));
        for (int b = 0; b < 8; b++) begin
            repeat (TB_BAUD) @(negedge clk);
            data[b] = sdiOut;
        end
        repeat (TB_BAUD) @(negedge clk);
        checkValue({name, " stop bit"}, 32'd1, 32'(sdiOut));
    endtask

    task automatic receiveFrames(input string name, input int n);
        sdiPkg::byteT bytes [sdiPkg::FRAME_BYTES];
        sdiPkg::byteT rx;
        for (int f = 0; f < n; f++) begin
            for (int b = 0; b < sdiPkg::FRAME_BYTES; b++) begin
                receiveByte(name, rx);
                bytes[b] = rx;
            end
            checkValue({name, " count"}, 32'(f), 32'({bytes[0], bytes[1]}));
            checkValue({name, " I"}, 32'(expI.pop_front()), 32'({bytes[2], bytes[3]}));
            checkValue({name, " Q"}, 32'(expQ.pop_front()), 32'({bytes[4], bytes[5]}));
        end
    endtask

    task automatic expectLineIdle(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checkValue({name, " idle line"}, 32'd1, 32'(sdiOut));
        end
    endtask

    task automatic resetAndRegisters();
        sdiPkg::wordT rd;
        @(negedge clk);
        checkValue("reset line", 32'd1, 32'(sdiOut));
        readReg(sdiPkg::ADDR_CONTROL, rd);
        checkValue("reset control", 32'h8000_0000, rd);    // empty, disabled, eye mode
        writeReg(sdiPkg::ADDR_BAUD, 32'(TB_BAUD));
        readReg(sdiPkg::ADDR_BAUD, rd);
        checkValue("baud readback", 32'(TB_BAUD), rd);
        readReg(4'd8, rd);
        checkValue("unknown address", 32'd0, rd);
    endtask

    task automatic constellationCapture();
        writeReg(sdiPkg::ADDR_CONTROL, 32'h81);
        repeat (ARM_WAIT) @(posedge clk);
        driveSymbols(5, 1);
        writeReg(sdiPkg::ADDR_CONTROL, 32'h01);
        receiveFrames("constellation", 5);
    endtask

    task automatic eyeCapture();
        writeReg(sdiPkg::ADDR_CONTROL, 32'h80);
        repeat (ARM_WAIT) @(posedge clk);
        driveEyeSync(1'b1, 1'b0);   // arming sync is not stored
        for (int k = 0; k < 4; k++) begin
            driveEyeSync(k[0], 1'b1);
        end
        writeReg(sdiPkg::ADDR_CONTROL, 32'h00);
        receiveFrames("eye capture", 4);
    endtask

    task automatic overflowDisarm();
        sdiPkg::wordT rd;
        writeReg(sdiPkg::ADDR_CONTROL, 32'h81);
        repeat (ARM_WAIT) @(posedge clk);
        driveSymbols(20, 0);
        // drain starts right away, so the readback runs alongside
        fork
            begin
                readReg(sdiPkg::ADDR_CONTROL, rd);
                checkValue("overflow control", 32'h0000_0001, rd);
            end
            receiveFrames("overflow", 16);
        join
        expectLineIdle("overflow", 2 * 10 * TB_BAUD);
        readReg(sdiPkg::ADDR_CONTROL, rd);
        checkValue("overflow drained", 32'h8000_0001, rd);
        expI.delete();  // symbols past the 16th were dropped
        expQ.delete();
    endtask

    task automatic countRestart();
        sdiPkg::wordT rd;
        writeReg(sdiPkg::ADDR_CONTROL, 32'h81);
        repeat (ARM_WAIT) @(posedge clk);
        driveSymbols(3, 2);
        writeReg(sdiPkg::ADDR_CONTROL, 32'h01);
        receiveFrames("count restart", 3);
        readReg(sdiPkg::ADDR_CONTROL, rd);
        checkValue("count restart control", 32'h8000_0001, rd);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timed out after %0d cycles waiting for the DUT", cycleCount);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        fifoFull = 1'b1;
        busReq   = '0;
        iSymEn   = 1'b0;
        iSymData = '0;
        qSymData = '0;
        eyeSync  = 1'b0;
        iEye     = '0;
        qEye     = '0;
        repeat (10) @(posedge clk);
        fifoFull <= 1'b0;

        resetAndRegisters();
        constellationCapture();
        eyeCapture();
        overflowDisarm();
        countRestart();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- tb/tbClock.sv
`timescale 1ns/1ns

module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;   // 8 ns period

endmodule
